// File: hw/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    typedef logic [6:0]  i2c_addr_t;    // 7-bit slave address
    typedef logic [15:0] i2c_word_t;    // One or two data bytes
    typedef logic [3:0]  wb_addr_t;     // Byte address, word index in bits 3:2
    typedef logic [31:0] wb_data_t;

    // One transfer as set up through TXDATA and CMD
    typedef struct packed {
        i2c_addr_t addr;
        i2c_word_t data;        // Sent MSB first, low byte only for one-byte writes
        logic      rw;          // 0 write, 1 read
        logic      two_bytes;
    } i2c_cmd_t;

    typedef struct packed {
        i2c_word_t data;        // Read data, first byte in 15:8 for two bytes
        logic      nack;        // Slave did not ACK address or data
    } i2c_rsp_t;

    typedef enum logic [1:0] {
        BIT_START,
        BIT_WRITE,
        BIT_READ,
        BIT_STOP
    } bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    bit_val;       // SDA level for BIT_WRITE, 0 is an ACK
    } bit_req_t;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_ADDR,
        SEQ_RW,
        SEQ_SLAVE_ACK,
        SEQ_WRITE_BYTE,
        SEQ_READ_BYTE,
        SEQ_MASTER_ACK,
        SEQ_STOP
    } seq_state_e;

    typedef enum logic [2:0] {
        BIT_IDLE,
        PHASE_A,
        PHASE_B,
        PHASE_C,
        PHASE_D
    } bit_state_e;

endpackage

`default_nettype wire

// File: hw/i2c_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_wb_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cyc,
    input  wire                    stb,
    input  wire                    we,
    input  wire i2c_pkg::wb_addr_t adr,
    input  wire i2c_pkg::wb_data_t dat_w,
    output i2c_pkg::wb_data_t      dat_r,
    output logic                   ack,
    output i2c_pkg::i2c_cmd_t      cmd,
    output logic                   cmd_valid,
    input  wire                    cmd_ready,
    input  wire i2c_pkg::i2c_rsp_t rsp,
    input  wire                    rsp_valid
);
    import i2c_pkg::*;

    localparam logic [1:0] REG_CMD    = 2'd0;
    localparam logic [1:0] REG_TXDATA = 2'd1;
    localparam logic [1:0] REG_RXDATA = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

    logic       bus_req;        // New bus cycle, not yet acked
    logic       bus_wr;
    logic [1:0] idx;
    logic       start;          // CMD write that launches a transfer
    i2c_word_t  tx_data;
    i2c_word_t  rx_data;
    logic       busy;
    logic       nack;
    wb_data_t   rd_data;

    assign bus_req = cyc && stb && !ack;
    assign bus_wr  = bus_req && we;
    assign idx     = adr[3:2];
    assign start   = bus_wr && idx == REG_CMD && !busy;   // Dropped while busy

    always_ff @(posedge clk)
    begin
        if (rst)
            ack <= 1'b0;
        else
            ack <= bus_req;
    end

    always_comb
    begin
        rd_data = '0;
        case (idx)
            REG_TXDATA: rd_data[15:0] = tx_data;
            REG_RXDATA: rd_data[15:0] = rx_data;
            REG_STATUS: rd_data[1:0]  = {nack, busy};
            default:    rd_data       = '0;               // CMD reads as zero
        endcase
    end

    // Read data captured on the edge that raises ack
    always_ff @(posedge clk)
    begin
        if (bus_req)
            dat_r <= rd_data;
    end

    always_ff @(posedge clk)
    begin
        if (bus_wr && idx == REG_TXDATA)
            tx_data <= dat_w[15:0];
        if (start)
        begin
            cmd.addr      <= dat_w[6:0];
            cmd.data      <= tx_data;
            cmd.rw        <= dat_w[8];
            cmd.two_bytes <= dat_w[9];
        end
        if (rsp_valid)
            rx_data <= rsp.data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cmd_valid <= 1'b0;
            busy      <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            if (start)
            begin
                cmd_valid <= 1'b1;
                busy      <= 1'b1;                        // Visible to the next STATUS read
            end
            else if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            if (rsp_valid)
            begin
                busy <= 1'b0;
                nack <= rsp.nack;
            end
        end
    end

    ack_only_in_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |-> cyc && stb);

endmodule

`default_nettype wire

// File: hw/i2c_byte_seq.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_seq (
    input  wire                    clk,
    input  wire                    rst,
    input  wire i2c_pkg::i2c_cmd_t cmd,
    input  wire                    cmd_valid,
    output logic                   cmd_ready,
    output i2c_pkg::i2c_rsp_t      rsp,
    output logic                   rsp_valid,
    output i2c_pkg::bit_req_t      req,
    output logic                   req_valid,
    input  wire                    req_ready,
    input  wire                    done,
    input  wire                    rx_bit
);
    import i2c_pkg::*;

    seq_state_e state;
    seq_state_e next_state;
    logic       accept;
    logic       pending;        // Bit op taken, waiting for done
    logic [2:0] bit_cnt;
    logic       more_bytes;     // Second byte still to transfer
    logic       data_phase;     // Address byte already ACKed
    logic       nack_q;
    i2c_addr_t  addr_q;
    logic       rw_q;
    i2c_word_t  shreg;          // TX leaves at bit 15, RX enters at bit 0

    assign cmd_ready = state == SEQ_IDLE;
    assign accept    = cmd_valid && cmd_ready;
    assign req_valid = state != SEQ_IDLE && !pending;

    assign rsp.data = rw_q ? shreg : '0;
    assign rsp.nack = nack_q;

    // Bit operation for the current state
    always_comb
    begin
        req.op      = BIT_WRITE;
        req.bit_val = 1'b1;
        case (state)
            SEQ_START:      req.op      = BIT_START;
            SEQ_ADDR:       req.bit_val = addr_q[bit_cnt];
            SEQ_RW:         req.bit_val = rw_q;
            SEQ_SLAVE_ACK:  req.op      = BIT_READ;
            SEQ_WRITE_BYTE: req.bit_val = shreg[15];
            SEQ_READ_BYTE:  req.op      = BIT_READ;
            SEQ_MASTER_ACK: req.bit_val = !more_bytes;    // NACK the last byte
            SEQ_STOP:       req.op      = BIT_STOP;
            default:        req.op      = BIT_WRITE;
        endcase
    end

    always_comb
    begin
        next_state = state;
        case (state)
            SEQ_IDLE:
                if (accept)
                    next_state = SEQ_START;
            SEQ_START:
                if (done)
                    next_state = SEQ_ADDR;
            SEQ_ADDR:
                if (done && bit_cnt == 3'd0)
                    next_state = SEQ_RW;
            SEQ_RW:
                if (done)
                    next_state = SEQ_SLAVE_ACK;
            SEQ_SLAVE_ACK:
                if (done)
                begin
                    if (rx_bit)
                        next_state = SEQ_STOP;            // Slave NACK ends the transfer
                    else if (!data_phase)
                        next_state = rw_q ? SEQ_READ_BYTE : SEQ_WRITE_BYTE;
                    else if (more_bytes)
                        next_state = SEQ_WRITE_BYTE;
                    else
                        next_state = SEQ_STOP;
                end
            SEQ_WRITE_BYTE:
                if (done && bit_cnt == 3'd0)
                    next_state = SEQ_SLAVE_ACK;
            SEQ_READ_BYTE:
                if (done && bit_cnt == 3'd0)
                    next_state = SEQ_MASTER_ACK;
            SEQ_MASTER_ACK:
                if (done)
                    next_state = more_bytes ? SEQ_READ_BYTE : SEQ_STOP;
            SEQ_STOP:
                if (done)
                    next_state = SEQ_IDLE;
            default:
                next_state = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= SEQ_IDLE;
            pending    <= 1'b0;
            rsp_valid  <= 1'b0;
            bit_cnt    <= 3'd0;
            more_bytes <= 1'b0;
            data_phase <= 1'b0;
            nack_q     <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            rsp_valid <= done && state == SEQ_STOP;
            if (req_valid && req_ready)
                pending <= 1'b1;
            else if (done)
                pending <= 1'b0;
            if (accept)
            begin
                more_bytes <= cmd.two_bytes;
                data_phase <= 1'b0;
                nack_q     <= 1'b0;
            end
            else if (done)
            begin
                case (state)
                    SEQ_START:
                        bit_cnt <= 3'd6;
                    SEQ_SLAVE_ACK:
                    begin
                        bit_cnt    <= 3'd7;
                        data_phase <= 1'b1;
                        if (rx_bit)
                            nack_q <= 1'b1;
                        else if (data_phase)
                            more_bytes <= 1'b0;
                    end
                    SEQ_MASTER_ACK:
                    begin
                        bit_cnt    <= 3'd7;
                        more_bytes <= 1'b0;
                    end
                    default:
                        bit_cnt <= bit_cnt - 3'd1;        // ADDR and data bits
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= cmd.addr;
            rw_q   <= cmd.rw;
            if (cmd.rw)
                shreg <= '0;
            else if (cmd.two_bytes)
                shreg <= cmd.data;
            else
                shreg <= {cmd.data[7:0], 8'h00};          // Single byte sent from the top
        end
        else if (done && (state == SEQ_WRITE_BYTE || state == SEQ_READ_BYTE))
            shreg <= {shreg[14:0], rw_q & rx_bit};
    end

    // A request is only offered once the bit controller has answered the last one
    new_req_after_done: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> req_ready);

endmodule

`default_nettype wire

// File: hw/i2c_bit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_ctrl #(
    parameter int CLK_DIV = 4
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire i2c_pkg::bit_req_t req,
    input  wire                    req_valid,
    output logic                   req_ready,
    output logic                   done,
    output logic                   rx_bit,
    output logic                   scl_oe,
    output logic                   sda_oe,
    input  wire                    scl_in,
    input  wire                    sda_in
);
    import i2c_pkg::*;

    localparam int               CNT_W    = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

    bit_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic             run;      // Counter advances, stalls while SCL is stretched
    logic             tick;     // Last clock of a quarter period
    bit_op_e          op_q;

    assign req_ready = state == BIT_IDLE;
    assign run       = state != PHASE_C || scl_in;
    assign tick      = run && cnt == CNT_LAST;

    always_ff @(posedge clk)
    begin
        if (rst || state == BIT_IDLE || tick)
            cnt <= '0;
        else if (run)
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= BIT_IDLE;
            done   <= 1'b0;
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                BIT_IDLE:
                    if (req_valid && req_ready)
                    begin
                        state <= PHASE_A;
                        if (req.op != BIT_START)
                            scl_oe <= 1'b1;
                        case (req.op)
                            BIT_WRITE: sda_oe <= !req.bit_val;
                            BIT_STOP:  sda_oe <= 1'b1;    // Low so it can rise with SCL high
                            default:   sda_oe <= 1'b0;
                        endcase
                    end
                PHASE_A:
                    if (tick)
                    begin
                        state  <= PHASE_B;
                        scl_oe <= 1'b0;
                    end
                PHASE_B:
                    if (tick)
                        state <= PHASE_C;
                PHASE_C:
                    if (tick)
                    begin
                        state <= PHASE_D;
                        case (op_q)
                            BIT_START: sda_oe <= 1'b1;            // SDA falls, SCL high
                            BIT_STOP:  sda_oe <= 1'b0;            // SDA rises, SCL high
                            default:   scl_oe <= 1'b1;
                        endcase
                    end
                PHASE_D:
                    if (tick)
                    begin
                        state <= BIT_IDLE;
                        done  <= 1'b1;
                        if (op_q == BIT_START)
                            scl_oe <= 1'b1;               // Hold time after START
                    end
                default:
                    state <= BIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            op_q <= req.op;
        if (state == PHASE_C && tick)
            rx_bit <= sda_in;
    end

    // Data only moves while SCL is held low, START and STOP excepted
    sda_with_scl_low: assert property (@(posedge clk) disable iff (rst)
        (sda_oe != $past(sda_oe)) && op_q != BIT_START && op_q != BIT_STOP
            |-> scl_oe && $past(scl_oe));

endmodule

`default_nettype wire

// File: hw/i2c_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_ctrl_top #(
    parameter int CLK_DIV = 4   // Clocks per quarter SCL period
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cyc,
    input  wire                    stb,
    input  wire                    we,
    input  wire i2c_pkg::wb_addr_t adr,
    input  wire i2c_pkg::wb_data_t dat_w,
    output i2c_pkg::wb_data_t      dat_r,
    output logic                   ack,
    output logic                   scl_oe,
    output logic                   sda_oe,
    input  wire                    scl_in,
    input  wire                    sda_in
);
    import i2c_pkg::*;

    i2c_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    i2c_rsp_t rsp;
    logic     rsp_valid;
    bit_req_t req;
    logic     req_valid;
    logic     req_ready;
    logic     done;
    logic     rx_bit;

    i2c_wb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    i2c_byte_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .done      (done),
        .rx_bit    (rx_bit)
    );

    i2c_bit_ctrl #(
        .CLK_DIV (CLK_DIV)
    ) u_bit (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .done      (done),
        .rx_bit    (rx_bit),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .scl_in    (scl_in),
        .sda_in    (sda_in)
    );

endmodule

`default_nettype wire

// File: dv/i2c_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
    parameter i2c_pkg::i2c_addr_t ADDR = 7'h2A,
    parameter i2c_pkg::i2c_word_t INIT = 16'h0000,
    parameter int                 SEED = 1
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                scl,
    input  wire                sda,
    input  wire                read_two,        // Length of the next read, set by the testbench
    output logic               scl_oe,
    output logic               sda_oe,
    output i2c_pkg::i2c_word_t reg_value
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_ADDR,
        SL_WRITE,
        SL_READ,
        SL_WAIT                                 // Master NACKed, waiting for STOP
    } slave_state_e;

    slave_state_e state;
    logic         scl_q;
    logic         sda_q;
    logic         scl_rise;
    logic         scl_fall;
    logic         start_cond;
    logic         stop_cond;
    logic [3:0]   bit_idx;                      // Bits sampled in the current frame
    logic [7:0]   shift;
    logic [7:0]   tx;
    logic [7:0]   first_byte;
    logic         rd;
    logic [1:0]   wcount;
    logic [7:0]   wbuf0;
    logic [7:0]   wbuf1;
    logic [2:0]   stretch;
    integer       seed;

    initial seed = SEED;

    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;
    assign start_cond = scl && scl_q && sda_q && !sda;
    assign stop_cond  = scl && scl_q && !sda_q && sda;
    assign first_byte = read_two ? reg_value[15:8] : reg_value[7:0];
    assign scl_oe     = stretch != 3'd0;

    // Lines are sampled on the falling clock, where the DUT outputs are stable
    always @(negedge clk)
    begin
        if (rst)
        begin
            state     <= SL_IDLE;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            bit_idx   <= 4'd0;
            sda_oe    <= 1'b0;
            stretch   <= 3'd0;
            wcount    <= 2'd0;
            rd        <= 1'b0;
            reg_value <= INIT;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (stretch != 3'd0)
                stretch <= stretch - 3'd1;
            if (start_cond)
            begin
                state   <= SL_ADDR;
                bit_idx <= 4'd0;
                wcount  <= 2'd0;
                sda_oe  <= 1'b0;
            end
            else if (stop_cond)
            begin
                if (state == SL_WRITE && wcount == 2'd1)
                    reg_value[7:0] <= wbuf0;                // One byte hits the low half
                else if (state == SL_WRITE && wcount == 2'd2)
                    reg_value <= {wbuf0, wbuf1};
                state  <= SL_IDLE;
                sda_oe <= 1'b0;
            end
            else if (state != SL_IDLE && scl_rise)
            begin
                shift   <= {shift[6:0], sda};
                bit_idx <= bit_idx + 4'd1;
            end
            else if (state != SL_IDLE && scl_fall)
            begin
                case (bit_idx)
                    4'd8:
                        case (state)
                            SL_ADDR:
                                if (shift[7:1] == ADDR)
                                begin
                                    rd     <= shift[0];
                                    sda_oe <= 1'b1;         // ACK own address
                                end
                                else
                                    state <= SL_IDLE;
                            SL_WRITE:
                            begin
                                if (wcount == 2'd0)
                                    wbuf0 <= shift;
                                else
                                    wbuf1 <= shift;
                                if (wcount != 2'd2)
                                    wcount <= wcount + 2'd1;
                                sda_oe <= 1'b1;
                            end
                            default:
                                sda_oe <= 1'b0;             // Master drives its ACK
                        endcase
                    4'd9:
                    begin
                        bit_idx <= 4'd0;
                        stretch <= 3'($random(seed));       // Hold SCL after the ACK slot
                        case (state)
                            SL_ADDR:
                                if (rd)
                                begin
                                    state  <= SL_READ;
                                    tx     <= first_byte;
                                    sda_oe <= !first_byte[7];
                                end
                                else
                                begin
                                    state  <= SL_WRITE;
                                    sda_oe <= 1'b0;
                                end
                            SL_READ:
                                if (!shift[0])
                                begin
                                    tx     <= reg_value[7:0];
                                    sda_oe <= !reg_value[7];
                                end
                                else
                                begin
                                    state  <= SL_WAIT;
                                    sda_oe <= 1'b0;
                                end
                            default:
                                sda_oe <= 1'b0;
                        endcase
                    end
                    default:
                        if (state == SL_READ && bit_idx != 4'd0)
                            sda_oe <= !tx[3'd7 - bit_idx[2:0]];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_i2c_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_ctrl;
    import i2c_pkg::*;

    localparam int        CLK_DIV        = 2;
    localparam i2c_addr_t SLAVE_ADDR     = 7'h2A;
    localparam i2c_word_t SLAVE_INIT     = 16'h5A3C;
    localparam int        SEED           = 32'h7f33_3680;
    localparam int        MAX_XFERS      = 40;
    localparam int        MAX_BIT_OPS    = 29;      // START, 8 + ACK, two bytes of 9, STOP
    localparam int        TIMEOUT_CYCLES = MAX_XFERS * MAX_BIT_OPS * (4 * CLK_DIV + 8);

    localparam wb_addr_t ADR_CMD    = 4'h0;
    localparam wb_addr_t ADR_TXDATA = 4'h4;
    localparam wb_addr_t ADR_RXDATA = 4'h8;
    localparam wb_addr_t ADR_STATUS = 4'hC;

    logic      clk = 1'b0;
    logic      rst;
    logic      cyc;
    logic      stb;
    logic      we;
    wb_addr_t  adr;
    wb_data_t  dat_w;
    wb_data_t  dat_r;
    logic      ack;
    logic      scl_oe;
    logic      sda_oe;
    logic      slv_scl_oe;
    logic      slv_sda_oe;
    logic      scl;
    logic      sda;
    logic      read_two;
    i2c_word_t slave_reg;
    i2c_word_t model_reg;                       // Expected slave register
    integer    seed;
    int        error_count;
    int        check_count;
    int        cycle_count = 0;
    logic [31:0] rnd;
    wb_data_t  status;
    wb_data_t  rx;

    // Open-drain lines with pull-ups
    assign scl = !scl_oe && !slv_scl_oe;
    assign sda = !sda_oe && !slv_sda_oe;

    always #10 clk = ~clk;

    i2c_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) u_i2c_ctrl_top (
        .clk    (clk),
        .rst    (rst),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack),
        .scl_oe (scl_oe),
        .sda_oe (sda_oe),
        .scl_in (scl),
        .sda_in (sda)
    );

    i2c_slave_model #(
        .ADDR (SLAVE_ADDR),
        .INIT (SLAVE_INIT),
        .SEED (SEED)
    ) u_slave (
        .clk       (clk),
        .rst       (rst),
        .scl       (scl),
        .sda       (sda),
        .read_two  (read_two),
        .scl_oe    (slv_scl_oe),
        .sda_oe    (slv_sda_oe),
        .reg_value (slave_reg)
    );

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("Error at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
        end
    endtask

    // Bus tasks start and end on a falling edge; cyc stays up through the ack edge
    task automatic wb_write(input wb_addr_t a, input wb_data_t d);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t a, output wb_data_t d);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        d = dat_r;
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic wait_not_busy(output wb_data_t st);
        wb_read(ADR_STATUS, st);
        while (st[0])
            wb_read(ADR_STATUS, st);
    endtask

    function automatic wb_data_t cmd_word(input i2c_addr_t a, input logic rw, input logic two);
        wb_data_t w;
        w    = '0;
        w[6:0] = a;
        w[8] = rw;
        w[9] = two;
        return w;
    endfunction

    // Slave register after a write, low byte only for one byte
    function automatic i2c_word_t predict_write(input i2c_word_t cur, input i2c_word_t data,
                                                input logic two);
        if (two)
            return data;
        return {cur[15:8], data[7:0]};
    endfunction

    function automatic i2c_word_t predict_read(input i2c_word_t cur, input logic two);
        if (two)
            return cur;                         // High byte arrives first
        return {8'h00, cur[7:0]};
    endfunction

    task automatic run_transfer(input i2c_addr_t a, input logic rw, input logic two,
                                input i2c_word_t data, output wb_data_t st, output wb_data_t rd);
        wb_data_t first;
        read_two = two;
        if (!rw)
            wb_write(ADR_TXDATA, {16'h0000, data});
        wb_write(ADR_CMD, cmd_word(a, rw, two));
        wb_read(ADR_STATUS, first);
        check_value(32'(first[0]), 32'd1, "busy on the STATUS read after CMD");
        wait_not_busy(st);
        wb_read(ADR_RXDATA, rd);
    endtask

    task automatic good_write(input logic two, input i2c_word_t data);
        wb_data_t st;
        wb_data_t rd;
        run_transfer(SLAVE_ADDR, 1'b0, two, data, st, rd);
        model_reg = predict_write(model_reg, data, two);
        check_value(32'(st[1]), 32'd0, "nack after write");
        check_value(32'(slave_reg), 32'(model_reg), "slave register after write");
    endtask

    task automatic good_read(input logic two);
        wb_data_t st;
        wb_data_t rd;
        run_transfer(SLAVE_ADDR, 1'b1, two, 16'h0000, st, rd);
        check_value(32'(st[1]), 32'd0, "nack after read");
        check_value(rd, {16'h0000, predict_read(model_reg, two)}, "read data");
    endtask

    // Second CMD lands while busy and must be dropped
    task automatic busy_cmd_test(input logic rw, input logic two, input i2c_word_t data);
        wb_data_t st;
        wb_data_t rd;
        read_two = two;
        if (!rw)
            wb_write(ADR_TXDATA, {16'h0000, data});
        wb_write(ADR_CMD, cmd_word(SLAVE_ADDR, rw, two));
        wb_write(ADR_CMD, cmd_word(SLAVE_ADDR, !rw, !two));
        wait_not_busy(st);
        check_value(32'(st[1]), 32'd0, "nack with dropped CMD");
        if (rw)
        begin
            wb_read(ADR_RXDATA, rd);
            check_value(rd, {16'h0000, predict_read(model_reg, two)}, "read with dropped CMD");
        end
        else
            model_reg = predict_write(model_reg, data, two);
        check_value(32'(slave_reg), 32'(model_reg), "slave register with dropped CMD");
        wb_read(ADR_STATUS, st);
        check_value(32'(st[0]), 32'd0, "no transfer from the dropped CMD");
    endtask

    initial
    begin
        rst         = 1'b1;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        read_two    = 1'b0;
        seed        = SEED;
        error_count = 0;
        check_count = 0;
        model_reg   = SLAVE_INIT;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_value(32'(ack), 32'd0, "ack after reset");
        check_value(32'(scl_oe), 32'd0, "scl_oe after reset");
        check_value(32'(sda_oe), 32'd0, "sda_oe after reset");
        wb_read(ADR_STATUS, status);
        check_value(status, 32'd0, "STATUS after reset");

        for (int i = 0; i < 8; i++)
        begin
            rnd = $random(seed);
            good_write(rnd[16], rnd[15:0]);
            rnd = $random(seed);
            good_read(rnd[16]);
        end

        for (int i = 0; i < 6; i++)
        begin
            rnd = $random(seed);
            good_read(rnd[16]);
        end

        for (int i = 0; i < 5; i++)
        begin
            rnd = $random(seed);
            while (rnd[6:0] == SLAVE_ADDR)
                rnd = $random(seed);
            run_transfer(rnd[6:0], rnd[8], rnd[9], rnd[31:16], status, rx);
            check_value(32'(status[1]), 32'd1, "nack for an unknown address");
            check_value(32'(slave_reg), 32'(model_reg), "slave register after unknown address");
        end
        good_read(1'b1);                        // nack flag clears again

        for (int i = 0; i < 4; i++)
        begin
            rnd = $random(seed);
            busy_cmd_test(rnd[17], rnd[16], rnd[15:0]);
        end

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: i2c_ctrl_top.f
hw/i2c_pkg.sv
hw/i2c_wb_regs.sv
hw/i2c_byte_seq.sv
hw/i2c_bit_ctrl.sv
hw/i2c_ctrl_top.sv
dv/i2c_slave_model.sv
dv/tb_i2c_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run with Verilator, exit status follows the testbench verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_i2c_ctrl -f i2c_ctrl_top.f \
    && ./obj_dir/Vtb_i2c_ctrl | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
